//--- hdl/cop_main_macros.svh
// ##############################
// board constants, clk is 24x the ratio base
// cpu_cen runs at NUM/DEN of clk
// ##############################
`ifndef COP_MAIN_MACROS_SVH
`define COP_MAIN_MACROS_SVH

// CPU clock enable ratio
`define COP_CEN_NUM 5
`define COP_CEN_DEN 24

// cpu_cen pulses held back after a blank starts
`define COP_DISP_WAIT 2

// word address is addr[COP_AW:1]
`define COP_AW 23

`endif

//--- hdl/cop_map_pkg.sv
// ##############################
// CPU address map types, 16-bit data bus only
// region is none when no strobe is active
// ##############################
`default_nettype none

package cop_map_pkg;

    // area hit by the current CPU access
    typedef enum logic [3:0] {
        region_rom,
        region_ram,
        region_disp,      // palette
        region_cab_joy,
        region_cab_sys,
        region_cab_dip,
        region_snd,
        region_mcu,
        region_prisel,
        region_mixpsel,
        region_vint_clr,
        region_none
    } cop_region_t;

    typedef logic [15:0] cop_word_t;    // one bus word

endpackage

`default_nettype wire

//--- hdl/cop_irq_pkg.sv
// ##############################
// interrupt levels and bus timing states
// levels are kept in true form
// ##############################
`default_nettype none

package cop_irq_pkg;

    typedef enum logic [2:0] {
        ipl_none   = 3'd0,
        ipl_ext    = 3'd4,    // expansion connector
        ipl_mcu    = 3'd5,
        ipl_vblank = 3'd6
    } cop_ipl_t;

    // DTACK generation
    typedef enum logic [1:0] {
        dtk_idle,
        dtk_wait_busy,
        dtk_ack
    } cop_dtack_state_t;

endpackage

`default_nettype wire

//--- hdl/cop_decoder.sv
// ##############################
// 68000 address decoder, combinational
// strobes need as_n low plus a data strobe
// ##############################
`default_nettype none
`include "cop_main_macros.svh"

module cop_decoder
    import cop_map_pkg::*;
(
    input  wire [`COP_AW:1] addr,
    input  wire             as_n,
    input  wire             uds_n,
    input  wire             lds_n,
    input  wire             rnw,
    output cop_region_t     region,
    output logic            rom_cs,
    output logic            ram_cs,
    output logic            disp_cs,
    output logic            snreq,
    output logic            mcu_wr,
    output logic            mcu_rd,
    output logic            prisel_cs,
    output logic            mixpsel_cs,
    output logic            vint_clr
);

    logic [`COP_AW:0] byte_addr;
    logic             bus_sel;

    assign byte_addr = {addr, 1'b0};
    assign bus_sel   = ~as_n & (~uds_n | ~lds_n);

    always_comb begin
        region = region_none;
        if (bus_sel) begin
            if (byte_addr < 24'h06_0000) begin
                if (rnw) region = region_rom;     // no writes to ROM
            end else if (byte_addr[`COP_AW:11] == 13'h0620) begin
                region = region_disp;             // 310000-3107FF
            end else if (byte_addr[`COP_AW:14] == 10'h3fe) begin
                region = region_ram;              // FF8000-FFBFFF
            end else begin
                // board registers, read or write only
                case ({rnw, byte_addr})
                    {1'b1, 24'h30_c000}: region = region_cab_joy;
                    {1'b1, 24'h30_c002}: region = region_cab_sys;
                    {1'b1, 24'h30_c004}: region = region_cab_dip;
                    {1'b0, 24'h30_c010}: region = region_prisel;
                    {1'b0, 24'h30_c012}: region = region_snd;
                    {1'b0, 24'h30_c014}: region = region_vint_clr;
                    {1'b0, 24'h30_c016},
                    {1'b1, 24'h30_c016}: region = region_mcu;
                    {1'b0, 24'h30_c018}: region = region_mixpsel;
                    default:             region = region_none;
                endcase
            end
        end
    end

    assign rom_cs     = region == region_rom;
    assign ram_cs     = region == region_ram;
    assign disp_cs    = region == region_disp;
    assign snreq      = region == region_snd;
    assign mcu_wr     = (region == region_mcu) & ~rnw;
    assign mcu_rd     = (region == region_mcu) & rnw;    // also acks the MCU irq
    assign prisel_cs  = region == region_prisel;
    assign mixpsel_cs = region == region_mixpsel;
    assign vint_clr   = region == region_vint_clr;

endmodule

`default_nettype wire

//--- hdl/cop_irq_ctrl.sv
// ##############################
// vblank and MCU interrupt latches
// ipl_n is active low, vblank has top priority
// ##############################
`default_nettype none

module cop_irq_ctrl
    import cop_irq_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        lvbl,
    input  wire        sec2,
    input  wire        nexirq,      // active low
    input  wire        vint_clr,
    input  wire        mcu_rd,
    output logic [2:0] ipl_n
);

    logic     lvbl_l, sec2_l;
    logic     vint, secirq;
    cop_ipl_t level;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            sec2_l <= 1'b1;     // no false edge out of reset
            vint   <= 1'b0;
            secirq <= 1'b0;
        end else begin
            lvbl_l <= lvbl;
            sec2_l <= sec2;
            if (vint_clr)
                vint <= 1'b0;
            else if (lvbl_l && !lvbl)
                vint <= 1'b1;   // start of vertical blank
            if (mcu_rd)
                secirq <= 1'b0;
            else if (!sec2_l && sec2)
                secirq <= 1'b1;
        end
    end

    always_comb begin
        if (vint)
            level = ipl_vblank;
        else if (secirq)
            level = ipl_mcu;
        else if (!nexirq)
            level = ipl_ext;
        else
            level = ipl_none;
    end

    assign ipl_n = ~level;

endmodule

`default_nettype wire

//--- hdl/cop_dtack.sv
// ##############################
// CPU clock enable and DTACK timing
// palette access waits for a blank
// ##############################
`default_nettype none
`include "cop_main_macros.svh"

module cop_dtack
    import cop_map_pkg::*;
    import cop_irq_pkg::*;
(
    input  wire              clk,
    input  wire              rst,
    input  wire              as_n,
    input  wire cop_region_t region,
    input  wire              rom_ok,
    input  wire              ram_ok,
    input  wire              lvbl,
    input  wire              lhbl,
    output logic             cpu_cen,
    output logic             dtack_n
);

    localparam int acc_w  = $clog2(`COP_CEN_DEN + `COP_CEN_NUM + 1);
    localparam int dcnt_w = $clog2(`COP_DISP_WAIT + 1);

    logic [acc_w-1:0]  cen_acc, acc_sum;
    logic              cen_next;
    cop_dtack_state_t  state;
    logic              as_armed;
    logic              rom_ok_l;
    logic              is_disp, disp_blank, disp_blank_l, disp_open;
    logic [dcnt_w-1:0] disp_cnt;
    logic              bus_busy;

    // fractional divider, cpu_cen is registered together with the FSM
    assign acc_sum  = cen_acc + acc_w'(`COP_CEN_NUM);
    assign cen_next = acc_sum >= acc_w'(`COP_CEN_DEN);

    assign is_disp    = region == region_disp;
    assign disp_blank = is_disp & (~lvbl | ~lhbl);
    assign bus_busy   = ((region == region_rom) & ~rom_ok_l) |
                        ((region == region_ram) & ~ram_ok)   |
                        (is_disp & (~disp_open | (disp_cnt != '0)));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cen_acc      <= '0;
            cpu_cen      <= 1'b0;
            state        <= dtk_idle;
            as_armed     <= 1'b0;
            rom_ok_l     <= 1'b0;
            disp_blank_l <= 1'b0;
            disp_open    <= 1'b0;
            disp_cnt     <= '0;
        end else begin
            cen_acc  <= cen_next ? acc_sum - acc_w'(`COP_CEN_DEN) : acc_sum;
            cpu_cen  <= cen_next;
            rom_ok_l <= rom_ok;     // ROM data lags ok by a clock

            case (state)
                dtk_idle: begin
                    as_armed <= 1'b0;
                    if (!as_n) state <= dtk_wait_busy;
                end
                dtk_wait_busy: begin
                    as_armed <= 1'b1;   // gives cpu_din its register stage
                    if (as_n)
                        state <= dtk_idle;
                    else if (as_armed && cen_next && !bus_busy)
                        state <= dtk_ack;
                end
                dtk_ack: if (as_n) state <= dtk_idle;
                default: state <= dtk_idle;
            endcase

            // display lock, opens on the blank edge seen by this access
            disp_blank_l <= disp_blank;
            if (state == dtk_idle) disp_open <= 1'b0;
            if (disp_blank && !disp_blank_l) begin
                disp_open <= 1'b1;
                disp_cnt  <= dcnt_w'(`COP_DISP_WAIT);
            end else if (cpu_cen && disp_cnt != '0) begin
                disp_cnt <= disp_cnt - 1'b1;
            end
        end
    end

    assign dtack_n = as_n | (state != dtk_ack);

endmodule

`default_nettype wire

//--- hdl/cop_read_mux.sv
// ##############################
// registered CPU read data
// unmapped reads give FFFF
// ##############################
`default_nettype none

module cop_read_mux
    import cop_map_pkg::*;
(
    input  wire              clk,
    input  wire cop_region_t region,
    input  wire cop_word_t   rom_data,
    input  wire cop_word_t   ram_data,
    input  wire cop_word_t   pal_dout,
    input  wire cop_word_t   mcu_dout,
    input  wire [8:0]        joystick1,
    input  wire [8:0]        joystick2,
    input  wire [1:0]        start_button,
    input  wire [1:0]        coin_input,
    input  wire              service,
    input  wire              lvbl,
    input  wire [7:0]        dipsw_a,
    input  wire [7:0]        dipsw_b,
    output cop_word_t        cpu_din
);

    logic [8:0] sort1, sort2;

    // direction bits come in reversed order on this board
    function automatic logic [8:0] sort_joy(input logic [8:0] joy);
        return {joy[8:4], joy[0], joy[1], joy[2], joy[3]};
    endfunction

    assign sort1 = sort_joy(joystick1);
    assign sort2 = sort_joy(joystick2);

    always_ff @(posedge clk) begin
        case (region)
            region_rom:     cpu_din <= rom_data;
            region_ram:     cpu_din <= ram_data;
            region_disp:    cpu_din <= pal_dout;
            region_mcu:     cpu_din <= mcu_dout;
            region_cab_joy: cpu_din <= {sort2[7:0], sort1[7:0]};
            region_cab_sys: begin
                cpu_din <= {8'hff,
                            ~lvbl,          // high during vblank
                            service,
                            coin_input,
                            start_button,
                            sort2[8],
                            sort1[8]};
            end
            region_cab_dip: cpu_din <= {dipsw_b, dipsw_a};
            default:        cpu_din <= 16'hffff;
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/cop_main.sv
// ##############################
// main CPU board glue, no 68000 inside
// bus signals come in on loose ports
// ##############################
`default_nettype none
`include "cop_main_macros.svh"

module cop_main
    import cop_map_pkg::*;
(
    input  wire                clk,
    input  wire                rst,

    input  wire                lvbl,
    input  wire                lhbl,
    input  wire                nexirq,
    input  wire                sec2,

    // CPU bus
    input  wire                as_n,
    input  wire                rnw,
    input  wire                uds_n,
    input  wire                lds_n,
    input  wire [`COP_AW:1]    addr,
    input  wire cop_word_t     cpu_dout,
    output cop_word_t          cpu_din,
    output logic               dtack_n,
    output logic [2:0]         ipl_n,
    output logic               cpu_cen,

    output logic               rom_cs,
    input  wire cop_word_t     rom_data,
    input  wire                rom_ok,

    output logic               ram_cs,
    input  wire cop_word_t     ram_data,
    input  wire                ram_ok,

    output logic [1:0]         pal_cs,      // upper, lower byte
    input  wire cop_word_t     pal_dout,

    output logic               snreq,
    output logic [7:0]         snd_latch,

    output cop_word_t          mcu_din,
    input  wire cop_word_t     mcu_dout,
    output logic               mcu_rd,

    output logic [2:0]         prisel,
    output logic               mixpsel,

    // cabinet
    input  wire [8:0]          joystick1,
    input  wire [8:0]          joystick2,
    input  wire [1:0]          start_button,
    input  wire [1:0]          coin_input,
    input  wire                service,
    input  wire [7:0]          dipsw_a,
    input  wire [7:0]          dipsw_b
);

    cop_region_t region;
    logic        disp_cs, mcu_wr, prisel_cs, mixpsel_cs, vint_clr;

    assign pal_cs = {2{disp_cs}} & ~{uds_n, lds_n};

    // board register latches
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd_latch <= 8'd0;
            mcu_din   <= 16'd0;
            prisel    <= 3'd0;
            mixpsel   <= 1'b0;
        end else begin
            if (snreq)      snd_latch <= cpu_dout[7:0];
            if (mcu_wr)     mcu_din   <= cpu_dout;
            if (prisel_cs)  prisel    <= cpu_dout[2:0];   // colour mixer priority
            if (mixpsel_cs) mixpsel   <= cpu_dout[0];     // object buffer select
        end
    end

    cop_decoder u_decoder (
        .addr       (addr),
        .as_n       (as_n),
        .uds_n      (uds_n),
        .lds_n      (lds_n),
        .rnw        (rnw),
        .region     (region),
        .rom_cs     (rom_cs),
        .ram_cs     (ram_cs),
        .disp_cs    (disp_cs),
        .snreq      (snreq),
        .mcu_wr     (mcu_wr),
        .mcu_rd     (mcu_rd),
        .prisel_cs  (prisel_cs),
        .mixpsel_cs (mixpsel_cs),
        .vint_clr   (vint_clr)
    );

    cop_irq_ctrl u_irq (
        .clk      (clk),
        .rst      (rst),
        .lvbl     (lvbl),
        .sec2     (sec2),
        .nexirq   (nexirq),
        .vint_clr (vint_clr),
        .mcu_rd   (mcu_rd),
        .ipl_n    (ipl_n)
    );

    cop_dtack u_dtack (
        .clk     (clk),
        .rst     (rst),
        .as_n    (as_n),
        .region  (region),
        .rom_ok  (rom_ok),
        .ram_ok  (ram_ok),
        .lvbl    (lvbl),
        .lhbl    (lhbl),
        .cpu_cen (cpu_cen),
        .dtack_n (dtack_n)
    );

    cop_read_mux u_read_mux (
        .clk          (clk),
        .region       (region),
        .rom_data     (rom_data),
        .ram_data     (ram_data),
        .pal_dout     (pal_dout),
        .mcu_dout     (mcu_dout),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .lvbl         (lvbl),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .cpu_din      (cpu_din)
    );

endmodule

`default_nettype wire

//--- testbench/cop_main_tb.sv
// ##############################
// bus-master testbench, plays the 68000
// runs testbench/cop_main_trace.txt from the project root
// ##############################
`default_nettype none

module cop_main_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int cen_num = 5;     // cpu_cen pulses per cen_den clocks
    localparam int cen_den = 24;

    logic        clk, rst;
    logic        lvbl, lhbl, nexirq, sec2;
    logic        as_n, rnw, uds_n, lds_n;
    logic [23:1] addr;
    logic [15:0] cpu_dout, cpu_din;
    logic        dtack_n, cpu_cen;
    logic [2:0]  ipl_n;
    logic        rom_cs, rom_ok, ram_cs, ram_ok;
    logic [15:0] rom_data, ram_data, pal_dout, mcu_dout, mcu_din;
    logic [1:0]  pal_cs;
    logic        snreq, mcu_rd, mixpsel;
    logic [7:0]  snd_latch;
    logic [2:0]  prisel;
    logic [8:0]  joystick1, joystick2;
    logic [1:0]  start_button, coin_input;
    logic        service;
    logic [7:0]  dipsw_a, dipsw_b;

    integer      seed = 57330;
    integer      line_count = 0;
    logic        trace_counted = 1'b0;
    integer      fd, n;
    logic [8*128-1:0] line;
    logic [8*12-1:0]  op;
    logic [23:0] f_addr;
    logic [15:0] f_data, f_exp;
    logic        snreq_seen, mcu_rd_seen;
    logic        rom_sel, ram_sel;
    integer      rom_wait, ram_wait;
    integer      cen_clock = 0;
    integer      cen_first;
    integer      cen_times[$];

    // memory models
    assign rom_data = addr[16:1];
    assign ram_data = ~addr[16:1];
    assign pal_dout = 16'h0c0c;
    assign mcu_dout = 16'ha55a;

    cop_main uut (
        .clk(clk), .rst(rst),
        .lvbl(lvbl), .lhbl(lhbl), .nexirq(nexirq), .sec2(sec2),
        .as_n(as_n), .rnw(rnw), .uds_n(uds_n), .lds_n(lds_n), .addr(addr),
        .cpu_dout(cpu_dout), .cpu_din(cpu_din), .dtack_n(dtack_n),
        .ipl_n(ipl_n), .cpu_cen(cpu_cen),
        .rom_cs(rom_cs), .rom_data(rom_data), .rom_ok(rom_ok),
        .ram_cs(ram_cs), .ram_data(ram_data), .ram_ok(ram_ok),
        .pal_cs(pal_cs), .pal_dout(pal_dout),
        .snreq(snreq), .snd_latch(snd_latch),
        .mcu_din(mcu_din), .mcu_dout(mcu_dout), .mcu_rd(mcu_rd),
        .prisel(prisel), .mixpsel(mixpsel),
        .joystick1(joystick1), .joystick2(joystick2),
        .start_button(start_button), .coin_input(coin_input),
        .service(service), .dipsw_a(dipsw_a), .dipsw_b(dipsw_b)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ok lines come up 0-5 clocks after the select
    always begin
        @(posedge clk);
        rom_sel = rom_cs;
        ram_sel = ram_cs;
        #1;
        if (!rom_sel) begin
            rom_ok   = 1'b0;
            rom_wait = $unsigned($random(seed)) % 6;
        end else if (rom_wait == 0)
            rom_ok = 1'b1;
        else
            rom_wait = rom_wait - 1;
        if (!ram_sel) begin
            ram_ok   = 1'b0;
            ram_wait = $unsigned($random(seed)) % 6;
        end else if (ram_wait == 0)
            ram_ok = 1'b1;
        else
            ram_wait = ram_wait - 1;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got === exp)
        else fail_run($sformatf("error: %s is %h, expected %h", name, got, exp));
    endtask

    task automatic check_ipl_after(input integer clocks, input logic [15:0] exp);
        repeat (clocks) @(posedge clk);
        #1;
        check_value("ipl_n", {13'd0, ipl_n}, exp);
    endtask

    // every cen_num-th pulse of cpu_cen comes cen_den clocks later
    always @(posedge clk) begin
        cen_clock = cen_clock + 1;
        if (cpu_cen) begin
            cen_times.push_back(cen_clock);
            if (cen_times.size() > cen_num) begin
                cen_first = cen_times.pop_front();
                check_value("cpu_cen spacing", 16'(cen_times[cen_num - 1] - cen_first),
                            16'(cen_den));
            end
        end
    end

    // bus cycle starts right after a cpu_cen
    task automatic start_access(input logic write, input logic [23:0] byte_addr,
                                input logic [15:0] wdata);
        do @(posedge clk); while (!cpu_cen);
        #1;
        addr        = byte_addr[23:1];
        rnw         = ~write;
        cpu_dout    = wdata;
        uds_n       = 1'b0;
        lds_n       = 1'b0;
        as_n        = 1'b0;
        snreq_seen  = 1'b0;
        mcu_rd_seen = 1'b0;
    endtask

    task automatic finish_access(output logic [15:0] rdata);
        do begin
            @(posedge clk);
            if (snreq) snreq_seen = 1'b1;
            if (mcu_rd) mcu_rd_seen = 1'b1;
        end while (!(cpu_cen && !dtack_n));
        rdata = cpu_din;    // registered word, stable here
        #1;
        as_n  = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        rnw   = 1'b1;
    endtask

    task automatic run_line(input logic [8*12-1:0] code, input logic [23:0] a,
                            input logic [15:0] d, input logic [15:0] e);
        logic [15:0] rdata;
        case (code)
            "read": begin
                start_access(1'b0, a, 16'h0000);
                finish_access(rdata);
                check_value("cpu_din", rdata, e);
                if (a == 24'h30c016) begin
                    assert (mcu_rd_seen)
                    else fail_run("mcu_rd never went high during the MCU read");
                end
            end
            "write": begin
                start_access(1'b1, a, d);
                finish_access(rdata);
                case (a)
                    24'h30c010: check_value("prisel", {13'd0, prisel}, e);
                    24'h30c012: begin
                        check_value("snd_latch", {8'd0, snd_latch}, e);
                        assert (snreq_seen)
                        else fail_run("snreq never went high during the sound write");
                    end
                    24'h30c014: check_value("ipl_n", {13'd0, ipl_n}, e);
                    24'h30c016: begin
                        check_value("mcu_din", mcu_din, e);
                        assert (!mcu_rd_seen)
                        else fail_run("mcu_rd went high during the mailbox write");
                    end
                    24'h30c018: check_value("mixpsel", {15'd0, mixpsel}, e);
                    default: fail_run("trace writes to an address with no latch to check");
                endcase
            end
            "pal_read": begin   // dtack_n must hold high for d clocks
                start_access(1'b0, a, 16'h0000);
                repeat (d) begin
                    @(posedge clk);
                    assert (dtack_n)
                    else fail_run("palette read was acknowledged during active video");
                    check_value("pal_cs", {14'd0, pal_cs}, 16'h0003);
                end
            end
            "ack": begin
                finish_access(rdata);
                check_value("cpu_din", rdata, e);
            end
            "cab": begin
                @(posedge clk);
                #1;
                case (a)
                    24'd0: joystick1 = d[8:0];
                    24'd1: joystick2 = d[8:0];
                    24'd2: start_button = d[1:0];
                    24'd3: coin_input = d[1:0];
                    24'd4: service = d[0];
                    24'd5: dipsw_a = d[7:0];
                    default: dipsw_b = d[7:0];
                endcase
            end
            "vblank": begin
                @(posedge clk);
                #1 lvbl = a[0];
                check_ipl_after(3, e);
            end
            "hblank": begin
                @(posedge clk);
                #1 lhbl = a[0];
                check_ipl_after(3, e);
            end
            "sec2": begin
                @(posedge clk);
                #1 sec2 = a[0];
                check_ipl_after(3, e);
            end
            "nexirq": begin
                @(posedge clk);
                #1 nexirq = a[0];
                check_ipl_after(3, e);
            end
            "wait": check_ipl_after(a, e);
            default: fail_run("unknown opcode in the trace file");
        endcase
    endtask

    initial begin
        rst = 1'b1;
        lvbl = 1'b1;
        lhbl = 1'b1;
        nexirq = 1'b1;
        sec2 = 1'b0;
        as_n = 1'b1;
        rnw = 1'b1;
        uds_n = 1'b1;
        lds_n = 1'b1;
        addr = '0;
        cpu_dout = 16'h0000;
        rom_ok = 1'b0;
        ram_ok = 1'b0;
        joystick1 = 9'h1ff;     // cabinet inputs idle high
        joystick2 = 9'h1ff;
        start_button = 2'b11;
        coin_input = 2'b11;
        service = 1'b1;
        dipsw_a = 8'hff;
        dipsw_b = 8'hff;
        snreq_seen = 1'b0;
        mcu_rd_seen = 1'b0;

        fd = $fopen("testbench/cop_main_trace.txt", "r");
        if (fd == 0) fail_run("cannot open the trace file");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h", op, f_addr, f_data, f_exp);
            if (n == 4 && op != "#") line_count = line_count + 1;
        end
        $fclose(fd);
        trace_counted = 1'b1;

        repeat (3) @(posedge clk);
        #1 rst = 1'b0;

        fd = $fopen("testbench/cop_main_trace.txt", "r");
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%s %h %h %h", op, f_addr, f_data, f_exp);
            if (n == 4 && op != "#") run_line(op, f_addr, f_data, f_exp);
        end
        $fclose(fd);

        $display("sim passed");
        $finish;
    end

    // watchdog, 2000 ns per trace line
    initial begin
        wait (trace_counted);
        #(line_count * 2000);
        fail_run("timeout: the trace did not finish in time");
    end

endmodule

`default_nettype wire

//--- testbench/cop_main_trace.txt
# columns: opcode address data expected, all hex
# cab: address picks the input, 0 joy1 1 joy2 2 start 3 coin 4 service 5 dip_a 6 dip_b
cab 0 1c1 0
cab 1 03b 0
cab 2 2 0
cab 3 1 0
cab 4 1 0
cab 5 5a 0
cab 6 c3 0
read 001234 0 091a
read 04abce 0 55e7
read ff8010 0 3ff7
read ffbffe 0 2000
read 200000 0 ffff
read 30c000 0 3dc8
read 30c002 0 ff59
read 30c004 0 c35a
write 30c012 1234 34
write 30c016 beef beef
write 30c010 00fd 5
write 30c018 0003 1
vblank 0 0 1
read 30c002 0 ffd9
sec2 1 0 1
write 30c014 0 2
nexirq 0 0 2
read 30c016 0 a55a
wait 2 0 3
nexirq 1 0 7
vblank 1 0 7
sec2 0 0 7
pal_read 310010 18 0
hblank 0 0 7
ack 0 0 0c0c
hblank 1 0 7

//--- cop_main.f
+incdir+hdl
hdl/cop_map_pkg.sv
hdl/cop_irq_pkg.sv
hdl/cop_decoder.sv
hdl/cop_irq_ctrl.sv
hdl/cop_dtack.sv
hdl/cop_read_mux.sv
hdl/cop_main.sv
testbench/cop_main_tb.sv

//--- Bender.yml
package:
  name: cop_main

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/cop_map_pkg.sv
      - hdl/cop_irq_pkg.sv
      - hdl/cop_decoder.sv
      - hdl/cop_irq_ctrl.sv
      - hdl/cop_dtack.sv
      - hdl/cop_read_mux.sv
      - hdl/cop_main.sv
  - target: test
    files:
      - testbench/cop_main_tb.sv
